// ==== all.f ====
+incdir+.
mab_arb_pkg.sv
mab_bus_pkg.sv
mab_ram_queue.sv
mab_membuf.sv
mab_bus_arbiter.sv
mab_top.sv
tb_mab_top.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_mab_top -f all.f -o sim_mab
	./obj_dir/sim_mab 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "Simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== mab_cases.txt ====
# op      addr  wdata     expected   (all hex)
# op is one of ifetch, load, store, flush, stall, resume
stall     0000  00000000  00000000
ifetch    0000  00000000  a5a50000
ifetch    0001  00000000  a5a40001
ifetch    0002  00000000  a5a70002
ifetch    0003  00000000  a5a60003
ifetch    0004  00000000  a5a10004
load      8000  00000000  25a58000
load      8001  00000000  25a48001
load      8002  00000000  25a78002
load      8003  00000000  25a68003
load      8004  00000000  25a18004
resume    0000  00000000  00000000
ifetch    0010  00000000  a5b50010
store     8010  deadbeef  00000000
load      8010  00000000  deadbeef
ifetch    0011  00000000  a5b40011
store     8011  12345678  00000000
ifetch    0012  00000000  a5b70012
load      8011  00000000  12345678
load      8000  00000000  25a58000
ifetch    0013  00000000  a5b60013
store     8000  0badf00d  00000000
load      8000  00000000  0badf00d
ifetch    0014  00000000  a5b10014
stall     0000  00000000  00000000
ifetch    0020  00000000  a5850020
ifetch    0021  00000000  a5840021
store     8020  ffffffff  00000000
load      8001  00000000  25a48001
flush     0000  00000000  00000000
resume    0000  00000000  00000000
load      8020  00000000  25858020
ifetch    0020  00000000  a5850020
ifetch    0005  00000000  a5a00005
store     8021  cafef00d  00000000
load      8021  00000000  cafef00d

// ==== tb_mab_top.sv ====
// Memory access front end testbench
`timescale 1ns/100ps
`include "mab_cfg.svh"

module tb_mab_top;
  import mab_bus_pkg::*;
  import mab_arb_pkg::*;

  localparam int TIMEOUT = 200;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     clr_i;
  logic     ena_i;
  logic     insn_req_valid_i;
  cpu_req_t insn_req_i;
  logic     insn_req_ready_o;
  logic     insn_rsp_valid_o;
  logic     data_req_valid_i;
  cpu_req_t data_req_i;
  logic     data_req_ready_o;
  logic     data_rsp_valid_o;
  data_t    rsp_data_o;
  logic     mem_req_o;
  mem_req_t mem_req_data_o;
  logic     mem_ack_i = 1'b0;
  logic     mem_rsp_valid_i = 1'b0;
  mem_rsp_t mem_rsp_i = '0;

  // Scoreboard per port indexed by port id
  cpu_req_t iss_req_q [2][$];
  data_t    iss_exp_q [2][$];
  data_t    rsp_exp_q [2][$];
  data_t    exp_cur [2];

  // Memory model state
  data_t    mem_a [0:65535];
  int       rsp_due_q [$];
  data_t    rsp_data_q [$];
  port_id_t rsp_tag_q [$];
  logic     stall = 1'b0;
  int       cycle = 0;
  logic [31:0] lfsr_q = 32'h0c602a3e;

  // Arbitration tracking
  logic     last_both = 1'b0;
  port_id_t last_tag = PORT_INSN;
  logic     first_xfer = 1'b1;

  mab_top u_mab_top (.*);

  always #2 clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic next_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  // Hold valid until ready is seen ahead of a rising edge
  task automatic send_req(input int port, input cpu_req_t r, input data_t e);
    int n;
    @(negedge clk_i);
    exp_cur[port] = e;
    if (port == 1) begin
      data_req_i       = r;
      data_req_valid_i = 1'b1;
    end else begin
      insn_req_i       = r;
      insn_req_valid_i = 1'b1;
    end
    n = 0;
    while (!((port == 1) ? data_req_ready_o : insn_req_ready_o)) begin
      @(negedge clk_i);
      n++;
      if (n > TIMEOUT) stop_run("Timeout waiting for request ready");
    end
    @(negedge clk_i);
    insn_req_valid_i = 1'b0;
    data_req_valid_i = 1'b0;
  endtask

  task automatic flush_bufs();
    @(negedge clk_i);
    clr_i = 1'b1;
    @(negedge clk_i);
    clr_i = 1'b0;
  endtask

  function automatic int outstanding();
    return iss_req_q[0].size() + iss_req_q[1].size() + rsp_exp_q[0].size()
           + rsp_exp_q[1].size() + rsp_due_q.size();
  endfunction

  ////////////////////
  // Memory driver
  ////////////////////

  always @(negedge clk_i) begin
    mem_ack_i = stall ? 1'b0 : next_bit();
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cycle) begin
      mem_rsp_valid_i = 1'b1;
      mem_rsp_i.rdata = rsp_data_q[0];
      mem_rsp_i.port  = rsp_tag_q[0];
    end else begin
      mem_rsp_valid_i = 1'b0;
      mem_rsp_i       = '0;
    end
  end

  ////////////////////
  // Monitor and memory
  ////////////////////

  always @(posedge clk_i) begin : monitor
    logic     rdy [2];
    logic     vld [2];
    cpu_req_t reqs [2];
    logic [1:0] pend;
    cpu_req_t r;
    port_id_t tag;
    data_t    rd;
    int       p;
    int       due;
    if (rst_ni) begin
      cycle++;
      rdy[0]  = insn_req_ready_o;
      rdy[1]  = data_req_ready_o;
      vld[0]  = insn_req_valid_i;
      vld[1]  = data_req_valid_i;
      reqs[0] = insn_req_i;
      reqs[1] = data_req_i;
      // Full after DEPTH queued plus one held head
      for (p = 0; p < 2; p++) begin
        check_value(32'(rdy[p]),
                    32'(!clr_i && iss_req_q[p].size() < `MAB_DEPTH + 1), "request ready");
        pend[p] = (iss_req_q[p].size() > 0) || (vld[p] && rdy[p]);
        if (vld[p] && rdy[p]) begin
          iss_req_q[p].push_back(reqs[p]);
          iss_exp_q[p].push_back(exp_cur[p]);
        end
      end
      // Request shown whenever a port has work and no flush is under way
      check_value(32'(mem_req_o), 32'(pend != 2'b00 && !clr_i), "memory request");
      if (mem_req_o && mem_ack_i) begin
        r   = mem_req_data_o.req;
        tag = mem_req_data_o.port;
        p   = int'(tag);
        if (iss_req_q[p].size() == 0) stop_run("Memory request from a port with none open");
        check_value(32'(r.addr), 32'(iss_req_q[p][0].addr), "request address");
        check_value(r.wdata, iss_req_q[p][0].wdata, "request write data");
        check_value(32'(r.we), 32'(iss_req_q[p][0].we), "request write flag");
        if (last_both) check_value(32'(tag != last_tag), 32'd1, "tag alternation");
        if (first_xfer && pend == 2'b11) begin
          check_value(32'(tag), 32'(PORT_INSN), "first tag after reset");
        end
        if (r.we) begin
          mem_a[r.addr] = r.wdata;
          rd = '0;
        end else begin
          rd = mem_a[r.addr];
        end
        rsp_exp_q[p].push_back(iss_exp_q[p][0]);
        void'(iss_req_q[p].pop_front());
        void'(iss_exp_q[p].pop_front());
        // One to three cycles and never ahead of an older response
        due = cycle + 1 + int'(next_bit()) + int'(next_bit());
        if (rsp_due_q.size() > 0 && due <= rsp_due_q[$]) due = rsp_due_q[$] + 1;
        rsp_due_q.push_back(due);
        rsp_data_q.push_back(rd);
        rsp_tag_q.push_back(tag);
        last_both  = (pend == 2'b11);
        last_tag   = tag;
        first_xfer = 1'b0;
      end
      check_value(32'(insn_rsp_valid_o),
                  32'(mem_rsp_valid_i && mem_rsp_i.port == PORT_INSN), "insn response valid");
      check_value(32'(data_rsp_valid_o),
                  32'(mem_rsp_valid_i && mem_rsp_i.port == PORT_DATA), "data response valid");
      if (mem_rsp_valid_i) begin
        p = int'(mem_rsp_i.port);
        if (rsp_exp_q[p].size() == 0) stop_run("Response on a port with none expected");
        check_value(rsp_data_o, rsp_exp_q[p][0], "response data");
        void'(rsp_exp_q[p].pop_front());
        void'(rsp_due_q.pop_front());
        void'(rsp_data_q.pop_front());
        void'(rsp_tag_q.pop_front());
      end
      // Flushed requests must never reach memory
      if (clr_i) begin
        for (p = 0; p < 2; p++) begin
          iss_req_q[p].delete();
          iss_exp_q[p].delete();
        end
        last_both = 1'b0;
      end
    end
  end

  ////////////////////
  // Case sequencer
  ////////////////////

  initial begin
    string       line;
    logic [63:0] op;
    addr_t       addr;
    data_t       wdata;
    data_t       expv;
    cpu_req_t    r;
    int          fd;
    int          n;
    rst_ni           = 1'b0;
    clr_i            = 1'b0;
    ena_i            = 1'b1;
    insn_req_valid_i = 1'b0;
    insn_req_i       = '0;
    data_req_valid_i = 1'b0;
    data_req_i       = '0;
    // Fill depends on every address bit
    for (n = 0; n < 65536; n++) mem_a[n] = {16'(n) ^ 16'ha5a5, 16'(n)};
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    fd = $fopen("mab_cases.txt", "r");
    if (fd == 0) stop_run("Cannot open mab_cases.txt");
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%s %h %h %h", op, addr, wdata, expv);
      if (n != 4) stop_run("Malformed line in mab_cases.txt");
      r.addr  = addr;
      r.wdata = wdata;
      r.we    = (op == "store");
      if (op == "ifetch") begin
        send_req(0, r, expv);
      end else if (op == "load" || op == "store") begin
        send_req(1, r, expv);
      end else if (op == "flush") begin
        flush_bufs();
      end else if (op == "stall") begin
        @(posedge clk_i);
        stall = 1'b1;
      end else if (op == "resume") begin
        @(posedge clk_i);
        stall = 1'b0;
      end else begin
        stop_run("Unknown operation in mab_cases.txt");
      end
    end
    $fclose(fd);
    // Drain everything still in flight
    n = 0;
    while (outstanding() != 0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (outstanding() != 0) begin
      $display("Timeout waiting for outstanding requests to complete");
      $display("Errors found");
      $fatal(1, "drain timeout");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// ==== mab_top.sv ====
// Memory access front end
`timescale 1ns/100ps

module mab_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clr_i,
  input  logic                  ena_i,
  // Instruction port
  input  logic                  insn_req_valid_i,
  input  mab_bus_pkg::cpu_req_t insn_req_i,
  output logic                  insn_req_ready_o,
  output logic                  insn_rsp_valid_o,
  // Data port
  input  logic                  data_req_valid_i,
  input  mab_bus_pkg::cpu_req_t data_req_i,
  output logic                  data_req_ready_o,
  output logic                  data_rsp_valid_o,
  // Read data for both ports
  output mab_bus_pkg::data_t    rsp_data_o,
  // Memory channel
  output logic                  mem_req_o,
  output mab_bus_pkg::mem_req_t mem_req_data_o,
  input  logic                  mem_ack_i,
  input  logic                  mem_rsp_valid_i,
  input  mab_bus_pkg::mem_rsp_t mem_rsp_i
);
  import mab_bus_pkg::*;

  // Buffer to arbiter
  logic     insn_pend;
  cpu_req_t insn_head;
  logic     insn_ack;
  logic     data_pend;
  cpu_req_t data_head;
  logic     data_ack;

  ////////////////////
  // Port buffers
  ////////////////////

  // Instruction fetches
  mab_membuf u_insn_buf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (clr_i),
    .ena_i       (ena_i),
    .req_valid_i (insn_req_valid_i),
    .req_i       (insn_req_i),
    .req_ready_o (insn_req_ready_o),
    .pend_o      (insn_pend),
    .head_o      (insn_head),
    .ack_i       (insn_ack)
  );

  // Loads and stores
  mab_membuf u_data_buf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clr_i       (clr_i),
    .ena_i       (ena_i),
    .req_valid_i (data_req_valid_i),
    .req_i       (data_req_i),
    .req_ready_o (data_req_ready_o),
    .pend_o      (data_pend),
    .head_o      (data_head),
    .ack_i       (data_ack)
  );

  ////////////////////
  // Arbiter
  ////////////////////

  mab_bus_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ena_i            (ena_i),
    .insn_pend_i      (insn_pend),
    .insn_head_i      (insn_head),
    .data_pend_i      (data_pend),
    .data_head_i      (data_head),
    .insn_ack_o       (insn_ack),
    .data_ack_o       (data_ack),
    .mem_req_o        (mem_req_o),
    .mem_req_data_o   (mem_req_data_o),
    .mem_ack_i        (mem_ack_i),
    .mem_rsp_valid_i  (mem_rsp_valid_i),
    .mem_rsp_i        (mem_rsp_i),
    .insn_rsp_valid_o (insn_rsp_valid_o),
    .data_rsp_valid_o (data_rsp_valid_o),
    .rsp_data_o       (rsp_data_o)
  );

endmodule

// ==== mab_bus_arbiter.sv ====
// Two-port memory bus arbiter
`timescale 1ns/100ps

module mab_bus_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  ena_i,
  // Buffer heads
  input  logic                  insn_pend_i,
  input  mab_bus_pkg::cpu_req_t insn_head_i,
  input  logic                  data_pend_i,
  input  mab_bus_pkg::cpu_req_t data_head_i,
  output logic                  insn_ack_o,
  output logic                  data_ack_o,
  // Memory request channel
  output logic                  mem_req_o,
  output mab_bus_pkg::mem_req_t mem_req_data_o,
  input  logic                  mem_ack_i,
  // Memory response channel
  input  logic                  mem_rsp_valid_i,
  input  mab_bus_pkg::mem_rsp_t mem_rsp_i,
  output logic                  insn_rsp_valid_o,
  output logic                  data_rsp_valid_o,
  output mab_bus_pkg::data_t    rsp_data_o
);
  import mab_arb_pkg::*;

  // Tie-break state
  arb_state_e state_q;
  arb_state_e state_d;

  // Winner of this cycle
  port_id_t sel;

  // Request shown last cycle and not taken
  logic     lock_q;
  port_id_t lock_port_q;
  logic     lock_vld;

  logic xfer;

  ////////////////////
  // Selection
  ////////////////////

  // Lock only counts while that head is still there, a flush may withdraw it
  assign lock_vld = lock_q & ((lock_port_q == PORT_DATA) ? data_pend_i : insn_pend_i);

  always_comb begin
    if (lock_vld) begin
      // Keep request stable until acked
      sel = lock_port_q;
    end else if (insn_pend_i & data_pend_i) begin
      sel = (state_q == PRIO_DATA) ? PORT_DATA : PORT_INSN;
    end else if (data_pend_i) begin
      sel = PORT_DATA;
    end else begin
      sel = PORT_INSN;
    end
  end

  // Winner's head plus its tag
  assign mem_req_o           = ena_i & (insn_pend_i | data_pend_i);
  assign mem_req_data_o.req  = (sel == PORT_DATA) ? data_head_i : insn_head_i;
  assign mem_req_data_o.port = sel;

  // Memory ack steered to the winner
  assign xfer       = mem_req_o & mem_ack_i;
  assign insn_ack_o = xfer & (sel == PORT_INSN);
  assign data_ack_o = xfer & (sel == PORT_DATA);

  ////////////////////
  // Priority FSM
  ////////////////////

  // Hand priority to the loser after each transfer
  always_comb begin
    state_d = state_q;
    if (xfer) begin
      state_d = (sel == PORT_INSN) ? PRIO_DATA : PRIO_INSN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= PRIO_INSN;
      lock_q      <= 1'b0;
      lock_port_q <= PORT_INSN;
    end else if (ena_i) begin
      state_q     <= state_d;
      lock_q      <= mem_req_o & ~mem_ack_i;
      lock_port_q <= sel;
    end
  end

  ////////////////////
  // Response routing
  ////////////////////

  // Tag decode, data bus shared by both ports
  assign insn_rsp_valid_o = mem_rsp_valid_i & (mem_rsp_i.port == PORT_INSN);
  assign data_rsp_valid_o = mem_rsp_valid_i & (mem_rsp_i.port == PORT_DATA);
  assign rsp_data_o       = mem_rsp_i.rdata;

endmodule

// ==== mab_membuf.sv ====
// Memory access buffer for one port
`timescale 1ns/100ps
`include "mab_cfg.svh"

module mab_membuf (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clr_i,
  input  logic                  ena_i,
  // CPU request
  input  logic                  req_valid_i,
  input  mab_bus_pkg::cpu_req_t req_i,
  output logic                  req_ready_o,
  // Towards the arbiter
  output logic                  pend_o,
  output mab_bus_pkg::cpu_req_t head_o,
  input  logic                  ack_i
);
  import mab_bus_pkg::*;

  // Up to DEPTH queued plus one held head
  localparam int CNT_W = $clog2(`MAB_DEPTH + 2);

  // Accepted but not yet acknowledged
  logic [CNT_W-1:0] pend_cnt_q;
  logic             busy;

  // Held head, payload only
  cpu_req_t hold_q;
  logic     hold_ld;

  // Queue hookup
  cpu_req_t queue_rdata;
  logic     queue_we;
  logic     queue_re;
  logic     queue_empty;
  logic     queue_full;

  logic accept;

  ////////////////////
  // Queue
  ////////////////////

  mab_ram_queue u_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .clr_i   (clr_i),
    .ena_i   (ena_i),
    .we_i    (queue_we),
    .wdata_i (req_i),
    .re_i    (queue_re),
    .rdata_o (queue_rdata),
    .empty_o (queue_empty),
    .full_o  (queue_full)
  );

  ////////////////////
  // Handshake
  ////////////////////

  // No accept during flush or while frozen
  assign req_ready_o = ena_i & ~clr_i & ~queue_full;
  assign accept      = req_valid_i & req_ready_o;

  // Something is held as long as the count is nonzero
  assign busy   = |pend_cnt_q;
  // Incoming request counts as pending for fall-through
  assign pend_o = ena_i & ~clr_i & (busy | accept);
  assign head_o = busy ? hold_q : req_i;

  // Queue only behind a held head, unless that head leaves with an empty queue
  assign queue_we = accept & busy & ~(ack_i & queue_empty);
  assign queue_re = ack_i & ~queue_empty;

  // Idle: load when not passed straight through. Busy: refill on ack
  assign hold_ld = busy ? ack_i : (accept & ~ack_i);

  always_ff @(posedge clk_i) begin
    if (hold_ld) hold_q <= queue_empty ? req_i : queue_rdata;
  end

  ////////////////////
  // Pending count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_cnt_q <= '0;
    end else if (clr_i) begin
      pend_cnt_q <= '0;
    end else if (ena_i) begin
      case ({accept, ack_i})
        2'b10:   pend_cnt_q <= pend_cnt_q + 1'b1;
        2'b01:   pend_cnt_q <= pend_cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== mab_ram_queue.sv ====
// Request queue
`timescale 1ns/100ps
`include "mab_cfg.svh"

module mab_ram_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clr_i,
  input  logic                  ena_i,
  input  logic                  we_i,
  input  mab_bus_pkg::cpu_req_t wdata_i,
  input  logic                  re_i,
  output mab_bus_pkg::cpu_req_t rdata_o,
  output logic                  empty_o,
  output logic                  full_o
);
  import mab_bus_pkg::*;

  localparam int DEPTH = `MAB_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Entry storage
  cpu_req_t mem_q [DEPTH];

  // Pointers and fill level
  logic [PTR_W-1:0] wp_q;
  logic [PTR_W-1:0] rp_q;
  logic [CNT_W-1:0] cnt_q;

  // Qualified strobes
  logic do_wr;
  logic do_rd;

  // Wrap at DEPTH, also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////
  // Strobes
  ////////////////////

  // Frozen while disabled
  assign do_wr = ena_i & we_i & ~full_o;
  assign do_rd = ena_i & re_i & ~empty_o;

  ////////////////////
  // Pointers
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wp_q  <= '0;
      rp_q  <= '0;
      cnt_q <= '0;
    end else if (clr_i) begin
      // Drop everything queued
      wp_q  <= '0;
      rp_q  <= '0;
      cnt_q <= '0;
    end else begin
      if (do_wr) wp_q <= ptr_inc(wp_q);
      if (do_rd) rp_q <= ptr_inc(rp_q);
      case ({do_wr, do_rd})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;  // Both or none, level unchanged
      endcase
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (do_wr) mem_q[wp_q] <= wdata_i;
  end

  // Oldest entry always visible
  assign rdata_o = mem_q[rp_q];
  assign empty_o = (cnt_q == '0);
  assign full_o  = (cnt_q == CNT_W'(DEPTH));

endmodule

// ==== mab_bus_pkg.sv ====
// CPU and memory channel payloads
`include "mab_cfg.svh"

package mab_bus_pkg;

  ////////////////////
  // Basic vectors
  ////////////////////

  // Address on both channels
  typedef logic [`MAB_AW-1:0] addr_t;

  // One data word
  typedef logic [`MAB_DW-1:0] data_t;

  ////////////////////
  // CPU side
  ////////////////////

  // Request as issued by a CPU port, 49 bits with default widths
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    logic  we;     // High for a store
  } cpu_req_t;

  ////////////////////
  // Memory side
  ////////////////////

  // Request on the shared memory channel
  typedef struct packed {
    cpu_req_t               req;
    mab_arb_pkg::port_id_t  port;   // Issuing port
  } mem_req_t;

  // Response from memory, tag copied from the request
  typedef struct packed {
    data_t                  rdata;
    mab_arb_pkg::port_id_t  port;
  } mem_rsp_t;

endpackage

// ==== mab_arb_pkg.sv ====
// Arbitration types

package mab_arb_pkg;

  ////////////////////
  // Port identity
  ////////////////////

  // Tag carried with each memory request and response
  typedef logic [0:0] port_id_t;

  // Instruction fetch port
  localparam port_id_t PORT_INSN = 1'b0;
  // Data load/store port
  localparam port_id_t PORT_DATA = 1'b1;

  ////////////////////
  // Priority state
  ////////////////////

  // Port that wins the next tie
  typedef enum logic {
    PRIO_INSN = 1'b0,
    PRIO_DATA = 1'b1
  } arb_state_e;

endpackage

// ==== mab_cfg.svh ====
// Memory access buffer configuration
`ifndef MAB_CFG_SVH
`define MAB_CFG_SVH

////////////////////
// Queue sizing
////////////////////

// Entries per buffer queue, not counting the held head
`define MAB_DEPTH 4

////////////////////
// Bus widths
////////////////////

// Address bits on CPU and memory side
`define MAB_AW 16
// Data word bits
`define MAB_DW 32

`endif
